/* Bender.yml */
package:
  name: icache

sources:
  - files:
      - hw/icache_pkg.sv
      - hw/sync_fifo.sv
      - hw/icache_arrays.sv
      - hw/icache_lookup.sv
      - hw/icache_refill.sv
      - hw/icache_top.sv
  - target: test
    files:
      - verification/axi_rom_model.sv
      - verification/icache_tb.sv

/* flist.f */
hw/icache_pkg.sv
hw/sync_fifo.sv
hw/icache_arrays.sv
hw/icache_lookup.sv
hw/icache_refill.sv
hw/icache_top.sv
verification/axi_rom_model.sv
verification/icache_tb.sv

/* hw/icache_arrays.sv */
`timescale 1ns/1ps

module icache_arrays
    import icache_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             rd_en,
    input  logic [INDEX_W-1:0]               rd_index,
    output logic [NUM_WAYS-1:0][TAG_W-1:0]   rd_tags,
    output logic [NUM_WAYS-1:0][LINE_W-1:0]  rd_lines,
    output logic [NUM_WAYS-1:0]              rd_valid,
    input  logic                             wr_en,
    input  line_write_t                      wr,
    input  logic                             invalidate
);

    logic [TAG_W-1:0]                  tag_mem  [NUM_WAYS][NUM_SETS];
    logic [LINE_W-1:0]                 data_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;

    // ****************************************
    // tag and data storage
    // ****************************************
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (wr_en && (wr.way == w)) begin
                tag_mem[w][wr.index]  <= wr.tag;
                data_mem[w][wr.index] <= wr.line;
            end
        end
    end

    // registered read, outputs hold until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_tags[w]  <= tag_mem[w][rd_index];
                rd_lines[w] <= data_mem[w][rd_index];
                rd_valid[w] <= valid_q[w][rd_index];
            end
        end
    end

    // ****************************************
    // valid bits
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (invalidate) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr.way][wr.index] <= 1'b1;
        end
    end

endmodule

/* hw/icache_lookup.sv */
`timescale 1ns/1ps

module icache_lookup
    import icache_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             req_valid,
    input  fetch_req_t                       req,
    output logic                             req_ready,
    output logic                             rd_en,
    output logic [INDEX_W-1:0]               rd_index,
    input  logic [NUM_WAYS-1:0][TAG_W-1:0]   rd_tags,
    input  logic [NUM_WAYS-1:0][LINE_W-1:0]  rd_lines,
    input  logic [NUM_WAYS-1:0]              rd_valid,
    output logic                             miss_valid,
    output refill_req_t                      miss,
    input  logic                             done_valid,
    input  refill_done_t                     done,
    output logic                             resp_push,
    output fetch_resp_t                      resp,
    input  logic                             resp_full,
    output logic                             idle
);

    logic                            stage_valid;
    fetch_req_t                      stage_req;
    logic                            hold_q;
    logic                            hold_load;
    logic                            miss_sent;
    logic                            fill_valid;
    refill_done_t                    fill_q;
    logic [NUM_WAYS-1:0][TAG_W-1:0]  hold_tags;
    logic [NUM_WAYS-1:0][LINE_W-1:0] hold_lines;
    logic [NUM_WAYS-1:0]             hold_valid;
    logic [NUM_WAYS-1:0][TAG_W-1:0]  use_tags;
    logic [NUM_WAYS-1:0][LINE_W-1:0] use_lines;
    logic [NUM_WAYS-1:0]             use_valid;
    logic [NUM_WAYS-1:0]             way_hit;
    logic                            hit;
    logic [LINE_W-1:0]               hit_line;
    logic [WORD_W-1:0]               hit_word;

    // pop straight into the array read
    assign req_ready = !stage_valid || resp_push;
    assign rd_en     = req_valid && req_ready;
    assign rd_index  = addr_index(req.addr);

    // ****************************************
    // tag compare
    // ****************************************
    assign use_tags  = hold_q ? hold_tags  : rd_tags;
    assign use_lines = hold_q ? hold_lines : rd_lines;
    assign use_valid = hold_q ? hold_valid : rd_valid;

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = use_valid[w] && (use_tags[w] == addr_tag(stage_req.addr));
            if (way_hit[w]) begin
                hit_line = hit_line | use_lines[w];
            end
        end
    end

    assign hit      = |way_hit;
    assign hit_word = stage_req.addr[3] ? hit_line[LINE_W-1:WORD_W] : hit_line[WORD_W-1:0];

    assign miss_valid    = stage_valid && !hit && !miss_sent;
    assign miss.addr     = {stage_req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign miss.word_sel = stage_req.addr[3];

    // refill result wins once it has come back
    assign resp_push = stage_valid && !resp_full && (fill_valid || hit);
    assign resp.resp = fill_valid ? fill_q.resp : RESP_OKAY;
    assign resp.data = fill_valid ? fill_q.data : hit_word;

    // first data cycle that does not retire
    assign hold_load = stage_valid && !hold_q && !resp_push;
    assign idle      = !stage_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            hold_q      <= 1'b0;
            miss_sent   <= 1'b0;
            fill_valid  <= 1'b0;
        end else begin
            if (rd_en) begin
                stage_valid <= 1'b1;
            end else if (resp_push) begin
                stage_valid <= 1'b0;
            end
            if (rd_en) begin
                hold_q <= 1'b0;
            end else if (hold_load) begin
                hold_q <= 1'b1;
            end
            if (resp_push) begin
                miss_sent  <= 1'b0;
                fill_valid <= 1'b0;
            end else begin
                if (miss_valid) begin
                    miss_sent <= 1'b1;
                end
                if (done_valid) begin
                    fill_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            stage_req <= req;
        end
        if (hold_load) begin
            hold_tags  <= rd_tags;
            hold_lines <= rd_lines;
            hold_valid <= rd_valid;
        end
        if (done_valid) begin
            fill_q <= done;
        end
    end

endmodule

/* hw/icache_pkg.sv */
package icache_pkg;

    // ****************************************
    // cache geometry
    // ****************************************
    localparam int ADDR_W     = 32;
    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 64;
    localparam int WAY_W      = $clog2(NUM_WAYS);
    localparam int INDEX_W    = $clog2(NUM_SETS);
    localparam int OFFSET_W   = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int LINE_W     = 128;
    localparam int WORD_W     = 64;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // ****************************************
    // read bus constants
    // ****************************************
    localparam int               ID_W           = 8;
    localparam logic [ID_W-1:0]  BUS_ID         = 8'd3;
    localparam logic [7:0]       BUS_LEN        = 8'd1;
    localparam logic [2:0]       BUS_SIZE       = 3'd3;
    localparam logic [1:0]       BUS_BURST_INCR = 2'b01;
    localparam logic [1:0]       RESP_OKAY      = 2'd0;
    localparam logic [1:0]       RESP_FAULT     = 2'd3;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [1:0]        resp;
        logic [WORD_W-1:0] data;
    } fetch_resp_t;

    typedef struct packed {
        logic [INDEX_W-1:0] index;
        logic [WAY_W-1:0]   way;
        logic [TAG_W-1:0]   tag;
        logic [LINE_W-1:0]  line;
    } line_write_t;

    // addr is line aligned, word_sel picks the upper half
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              word_sel;
    } refill_req_t;

    typedef struct packed {
        logic [1:0]        resp;
        logic [WORD_W-1:0] data;
    } refill_done_t;

    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:ADDR_W-TAG_W];
    endfunction

    function automatic logic [INDEX_W-1:0] addr_index(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W+INDEX_W-1:OFFSET_W];
    endfunction

endpackage

/* hw/icache_refill.sv */
`timescale 1ns/1ps

module icache_refill
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              miss_valid,
    input  refill_req_t       miss,
    output logic              done_valid,
    output refill_done_t      done,
    output logic              wr_en,
    output line_write_t       wr,
    output logic              idle,
    output logic              icache_arvalid,
    input  logic              icache_arready,
    output logic [ADDR_W-1:0] icache_araddr,
    output logic [7:0]        icache_arlen,
    output logic [2:0]        icache_arsize,
    output logic [1:0]        icache_arburst,
    output logic [ID_W-1:0]   icache_arid,
    input  logic              icache_rvalid,
    output logic              icache_rready,
    input  logic [ID_W-1:0]   icache_rid,
    input  logic [1:0]        icache_rresp,
    input  logic [WORD_W-1:0] icache_rdata,
    input  logic              icache_rlast
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_BEAT0,
        S_BEAT1,
        S_WRITE,
        S_DONE
    } state_t;

    state_t            state;
    logic              fault_q;
    logic              beat;
    logic              beat_bad;
    logic [7:0]        lfsr_q;
    logic [ADDR_W-1:0] addr_q;
    logic              word_sel_q;
    logic [LINE_W-1:0] line_q;

    // beats carrying another id are not ours
    assign beat     = icache_rvalid && icache_rready && (icache_rid == BUS_ID);
    assign beat_bad = icache_rresp != RESP_OKAY;

    // ****************************************
    // miss FSM
    // ****************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            fault_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (miss_valid) begin
                        state   <= S_ADDR;
                        fault_q <= 1'b0;
                    end
                end
                S_ADDR: begin
                    if (icache_arready) begin
                        state <= S_BEAT0;
                    end
                end
                S_BEAT0: begin
                    if (beat) begin
                        fault_q <= beat_bad;
                        state   <= S_BEAT1;
                        // burst cut short, no line to keep
                        if (icache_rlast) begin
                            fault_q <= 1'b1;
                            state   <= S_DONE;
                        end
                    end
                end
                S_BEAT1: begin
                    if (beat) begin
                        if (beat_bad || !icache_rlast) begin
                            fault_q <= 1'b1;
                        end
                        if (icache_rlast) begin
                            state <= (fault_q || beat_bad) ? S_DONE : S_WRITE;
                        end
                    end
                end
                S_WRITE: begin
                    state <= S_DONE;
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && miss_valid) begin
            addr_q     <= miss.addr;
            word_sel_q <= miss.word_sel;
        end
        if (beat && (state == S_BEAT0)) begin
            line_q[WORD_W-1:0] <= icache_rdata;
        end
        if (beat && (state == S_BEAT1)) begin
            line_q[LINE_W-1:WORD_W] <= icache_rdata;
        end
    end

    // victim pick, x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= 8'h01;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    // ****************************************
    // outputs
    // ****************************************
    assign icache_arvalid = (state == S_ADDR);
    assign icache_araddr  = addr_q;
    assign icache_arlen   = BUS_LEN;
    assign icache_arsize  = BUS_SIZE;
    assign icache_arburst = BUS_BURST_INCR;
    assign icache_arid    = BUS_ID;
    assign icache_rready  = 1'b1;

    assign wr_en    = (state == S_WRITE);
    assign wr.index = addr_index(addr_q);
    assign wr.way   = lfsr_q[WAY_W-1:0];
    assign wr.tag   = addr_tag(addr_q);
    assign wr.line  = line_q;

    assign done_valid = (state == S_DONE);
    assign done.resp  = fault_q ? RESP_FAULT : RESP_OKAY;
    assign done.data  = word_sel_q ? line_q[LINE_W-1:WORD_W] : line_q[WORD_W-1:0];
    assign idle       = (state == S_IDLE);

endmodule

/* hw/icache_top.sv */
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ifu_arvalid,
    input  logic [ADDR_W-1:0] ifu_araddr,
    output logic              ifu_arready,
    input  logic              ifu_rready,
    output logic              ifu_rvalid,
    output logic [1:0]        ifu_rresp,
    output logic [WORD_W-1:0] ifu_rdata,
    input  logic              flush_i_valid,
    output logic              flush_i_ready,
    output logic              icache_arvalid,
    output logic [ADDR_W-1:0] icache_araddr,
    output logic [7:0]        icache_arlen,
    output logic [2:0]        icache_arsize,
    output logic [1:0]        icache_arburst,
    output logic [ID_W-1:0]   icache_arid,
    input  logic              icache_arready,
    input  logic              icache_rvalid,
    input  logic [ID_W-1:0]   icache_rid,
    input  logic [1:0]        icache_rresp,
    input  logic [WORD_W-1:0] icache_rdata,
    input  logic              icache_rlast,
    output logic              icache_rready
);

    fetch_req_t                      req_in;
    fetch_req_t                      req_head;
    logic                            req_full;
    logic                            req_empty;
    fetch_resp_t                     resp_in;
    fetch_resp_t                     resp_head;
    logic                            resp_push;
    logic                            resp_full;
    logic                            resp_empty;
    logic                            rd_en;
    logic [INDEX_W-1:0]              rd_index;
    logic [NUM_WAYS-1:0][TAG_W-1:0]  rd_tags;
    logic [NUM_WAYS-1:0][LINE_W-1:0] rd_lines;
    logic [NUM_WAYS-1:0]             rd_valid;
    logic                            wr_en;
    line_write_t                     wr;
    logic                            miss_valid;
    refill_req_t                     miss;
    logic                            done_valid;
    refill_done_t                    done;
    logic                            lookup_idle;
    logic                            refill_idle;

    assign req_in.addr   = ifu_araddr;
    assign ifu_arready   = !req_full;
    assign ifu_rvalid    = !resp_empty;
    assign ifu_rresp     = resp_head.resp;
    assign ifu_rdata     = resp_head.data;
    // fence only once nothing is in flight
    assign flush_i_ready = req_empty && lookup_idle && refill_idle;

    sync_fifo #(.payload_t(fetch_req_t)) u_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (ifu_arvalid),
        .push_data (req_in),
        .full      (req_full),
        .pop       (rd_en),
        .pop_data  (req_head),
        .empty     (req_empty)
    );

    icache_arrays u_arrays (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .rd_tags    (rd_tags),
        .rd_lines   (rd_lines),
        .rd_valid   (rd_valid),
        .wr_en      (wr_en),
        .wr         (wr),
        .invalidate (flush_i_valid && flush_i_ready)
    );

    icache_lookup u_lookup (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (!req_empty),
        .req        (req_head),
        .req_ready  (),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .rd_tags    (rd_tags),
        .rd_lines   (rd_lines),
        .rd_valid   (rd_valid),
        .miss_valid (miss_valid),
        .miss       (miss),
        .done_valid (done_valid),
        .done       (done),
        .resp_push  (resp_push),
        .resp       (resp_in),
        .resp_full  (resp_full),
        .idle       (lookup_idle)
    );

    icache_refill u_refill (
        .clk            (clk),
        .rst_n          (rst_n),
        .miss_valid     (miss_valid),
        .miss           (miss),
        .done_valid     (done_valid),
        .done           (done),
        .wr_en          (wr_en),
        .wr             (wr),
        .idle           (refill_idle),
        .icache_arvalid (icache_arvalid),
        .icache_arready (icache_arready),
        .icache_araddr  (icache_araddr),
        .icache_arlen   (icache_arlen),
        .icache_arsize  (icache_arsize),
        .icache_arburst (icache_arburst),
        .icache_arid    (icache_arid),
        .icache_rvalid  (icache_rvalid),
        .icache_rready  (icache_rready),
        .icache_rid     (icache_rid),
        .icache_rresp   (icache_rresp),
        .icache_rdata   (icache_rdata),
        .icache_rlast   (icache_rlast)
    );

    sync_fifo #(.payload_t(fetch_resp_t)) u_resp_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (resp_push),
        .push_data (resp_in),
        .full      (resp_full),
        .pop       (ifu_rready),
        .pop_data  (resp_head),
        .empty     (resp_empty)
    );

endmodule

/* hw/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo
    import icache_pkg::*;
#(
    parameter type payload_t = fetch_req_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    payload_t             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W:0]  wr_ptr;
    logic [FIFO_PTR_W:0]  rd_ptr;
    logic                 do_push;
    logic                 do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // extra msb on each pointer tells full from empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[FIFO_PTR_W-1:0]] <= push_data;
        end
    end

    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[FIFO_PTR_W] != rd_ptr[FIFO_PTR_W]) &&
                      (wr_ptr[FIFO_PTR_W-1:0] == rd_ptr[FIFO_PTR_W-1:0]);
    assign pop_data = mem[rd_ptr[FIFO_PTR_W-1:0]];

endmodule

/* verification/axi_rom_model.sv */
`timescale 1ns/1ps

module axi_rom_model
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              arvalid,
    input  logic [ADDR_W-1:0] araddr,
    output logic              arready,
    output logic              rvalid,
    output logic [ID_W-1:0]   rid,
    output logic [1:0]        rresp,
    output logic [WORD_W-1:0] rdata,
    output logic              rlast,
    input  logic              rready,
    output int                ar_count
);

    // one burst at a time, outputs change on the falling edge
    initial begin
        logic [ADDR_W-1:0] line_addr;
        logic [ADDR_W-1:0] word_addr;
        arready  = 1'b0;
        rvalid   = 1'b0;
        rid      = BUS_ID;
        rresp    = 2'd0;
        rdata    = '0;
        rlast    = 1'b0;
        ar_count = 0;
        forever begin
            @(posedge clk);
            if (rst_n && arvalid) begin
                line_addr = araddr;
                @(negedge clk);
                repeat ($urandom_range(3, 0)) @(negedge clk);
                arready = 1'b1;
                @(posedge clk);
                ar_count++;
                @(negedge clk);
                arready = 1'b0;
                for (int b = 0; b < 2; b++) begin
                    repeat ($urandom_range(3, 0)) @(negedge clk);
                    word_addr = line_addr + ADDR_W'(8 * b);
                    rvalid    = 1'b1;
                    rdata     = {word_addr, ~word_addr};
                    // upper half of the map is unmapped
                    rresp     = (line_addr[31] && b == 0) ? 2'd2 : 2'd0;
                    rlast     = (b == 1);
                    @(posedge clk);
                    while (!rready) @(posedge clk);
                    @(negedge clk);
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                    rresp  = 2'd0;
                end
            end
        end
    end

endmodule

/* verification/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    localparam int MAX_REQUESTS   = 60;
    localparam int REFILL_WORST   = 20;
    localparam int TIMEOUT_CYCLES = MAX_REQUESTS * REFILL_WORST + 40;
    localparam logic [31:0] SAME_SET [3] = '{32'h0002_0040, 32'h0003_0040, 32'h0004_0040};

    logic              clk;
    logic              rst_n;
    logic              ifu_arvalid;
    logic [31:0]       ifu_araddr;
    logic              ifu_arready;
    logic              ifu_rready;
    logic              ifu_rvalid;
    logic [1:0]        ifu_rresp;
    logic [63:0]       ifu_rdata;
    logic              flush_i_valid;
    logic              flush_i_ready;
    logic              icache_arvalid;
    logic [31:0]       icache_araddr;
    logic [7:0]        icache_arlen;
    logic [2:0]        icache_arsize;
    logic [1:0]        icache_arburst;
    logic [7:0]        icache_arid;
    logic              icache_arready;
    logic              icache_rvalid;
    logic [7:0]        icache_rid;
    logic [1:0]        icache_rresp;
    logic [63:0]       icache_rdata;
    logic              icache_rlast;
    logic              icache_rready;
    int                ar_count;
    logic [31:0]       expected_addr [$];
    int                errors    = 0;
    int                checks    = 0;
    int                tests     = 0;
    int                requests  = 0;
    int                responses = 0;
    int                cycles    = 0;

    icache_top UUT (.*);

    axi_rom_model u_rom (
        .clk      (clk),
        .rst_n    (rst_n),
        .arvalid  (icache_arvalid),
        .araddr   (icache_araddr),
        .arready  (icache_arready),
        .rvalid   (icache_rvalid),
        .rid      (icache_rid),
        .rresp    (icache_rresp),
        .rdata    (icache_rdata),
        .rlast    (icache_rlast),
        .rready   (icache_rready),
        .ar_count (ar_count)
    );

    always #5 clk = ~clk;

    // word at A is A over ~A, per 8-byte word
    function automatic logic [63:0] rule_word(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:3], 3'b000};
        return {word_addr, ~word_addr};
    endfunction

    function automatic logic [31:0] random_addr();
        logic [31:0] addr;
        addr = $urandom & 32'h0000_1ff8;
        if ($urandom_range(7, 0) == 0) begin
            addr[31] = 1'b1;
        end
        return addr;
    endfunction

    // ****************************************
    // scoreboard and bus monitor
    // ****************************************
    task automatic check_response();
        logic [31:0] addr;
        logic [1:0]  exp_resp;
        checks++;
        assert (expected_addr.size() != 0) else begin
            $display("response arrived with no request outstanding");
            errors++;
        end
        if (expected_addr.size() != 0) begin
            addr     = expected_addr.pop_front();
            exp_resp = addr[31] ? 2'd3 : 2'd0;
            checks++;
            assert (ifu_rresp == exp_resp) else begin
                $display("[ERROR] ifu_rresp got %h expected %h addr %h", ifu_rresp, exp_resp, addr);
                errors++;
            end
            if (exp_resp == 2'd0) begin
                checks++;
                assert (ifu_rdata == rule_word(addr)) else begin
                    $display("[ERROR] ifu_rdata got %h expected %h", ifu_rdata, rule_word(addr));
                    errors++;
                end
            end
            responses++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && ifu_arvalid && ifu_arready) begin
            expected_addr.push_back(ifu_araddr);
            requests++;
        end
        if (rst_n && ifu_rvalid && ifu_rready) begin
            check_response();
        end
        if (rst_n && icache_arvalid && icache_arready) begin
            checks++;
            assert (icache_arlen == 8'd1 && icache_arsize == 3'd3 &&
                    icache_arburst == 2'b01 && icache_arid == 8'd3) else begin
                $display("[ERROR] icache_arlen/arsize/arburst/arid got %h %h %h %h expected 01 3 1 03",
                         icache_arlen, icache_arsize, icache_arburst, icache_arid);
                errors++;
            end
            checks++;
            assert (icache_araddr[3:0] == 4'h0) else begin
                $display("[ERROR] icache_araddr got %h expected line aligned", icache_araddr);
                errors++;
            end
        end
        // R channel never back-pressures
        if (rst_n && icache_rvalid) begin
            checks++;
            assert (icache_rready) else begin
                $display("[ERROR] icache_rready got %h expected 1", icache_rready);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d responses pending",
                     cycles, expected_addr.size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ****************************************
    // stimulus tasks
    // ****************************************
    task automatic fetch_word(input logic [31:0] addr);
        @(negedge clk);
        ifu_arvalid = 1'b1;
        ifu_araddr  = addr;
        @(posedge clk);
        while (!ifu_arready) @(posedge clk);
        @(negedge clk);
        ifu_arvalid = 1'b0;
    endtask

    task automatic wait_responses();
        while (expected_addr.size() != 0) @(negedge clk);
    endtask

    task automatic fence_cache();
        @(negedge clk);
        flush_i_valid = 1'b1;
        @(posedge clk);
        while (!flush_i_ready) @(posedge clk);
        @(negedge clk);
        flush_i_valid = 1'b0;
    endtask

    task automatic check_ar_count(input int exp_count);
        checks++;
        assert (ar_count == exp_count) else begin
            $display("[ERROR] ar_count got %h expected %h", ar_count, exp_count);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "failed");
    endtask

    // ****************************************
    // tests
    // ****************************************
    initial begin
        int   errors_before;
        int   count_before;
        logic saw_full;
        void'($urandom(32'h1d92));
        clk           = 1'b0;
        rst_n         = 1'b0;
        ifu_arvalid   = 1'b0;
        ifu_araddr    = '0;
        ifu_rready    = 1'b1;
        flush_i_valid = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        errors_before = errors;
        checks++;
        assert (!ifu_rvalid && !icache_arvalid && flush_i_ready) else begin
            $display("outputs not in their reset state after reset release");
            errors++;
        end
        fetch_word(32'h0000_1000);
        wait_responses();
        check_ar_count(1);
        report_test("first miss", errors_before);

        errors_before = errors;
        count_before  = ar_count;
        repeat (2) begin
            fetch_word(32'h0000_1000);
            fetch_word(32'h0000_1008);
        end
        wait_responses();
        check_ar_count(count_before);
        report_test("hits on both halves", errors_before);

        // three tags on set 4 with two ways
        errors_before = errors;
        for (int round = 0; round < 4; round++) begin
            for (int i = 0; i < 3; i++) begin
                count_before = ar_count;
                fetch_word(SAME_SET[i] | (round[0] ? 32'h8 : 32'h0));
                wait_responses();
                checks++;
                assert (ar_count - count_before <= 1) else begin
                    $display("[ERROR] ar_count got %h expected at most %h",
                             ar_count, count_before + 1);
                    errors++;
                end
                count_before = ar_count;
                fetch_word(SAME_SET[i] | (round[0] ? 32'h0 : 32'h8));
                wait_responses();
                check_ar_count(count_before);
            end
        end
        report_test("same set eviction", errors_before);

        errors_before = errors;
        count_before  = ar_count;
        fetch_word(32'h8000_2000);
        wait_responses();
        check_ar_count(count_before + 1);
        fetch_word(32'h8000_2008);
        wait_responses();
        check_ar_count(count_before + 2);
        report_test("bus error", errors_before);

        errors_before = errors;
        fetch_word(32'h0000_1000);
        wait_responses();
        count_before = ar_count;
        fence_cache();
        fetch_word(32'h0000_1000);
        wait_responses();
        check_ar_count(count_before + 1);
        fetch_word(32'h0000_1008);
        wait_responses();
        check_ar_count(count_before + 1);
        report_test("fence.i", errors_before);

        // hold off the read side until the request FIFO backs up
        errors_before = errors;
        saw_full      = 1'b0;
        @(negedge clk);
        ifu_rready  = 1'b0;
        ifu_arvalid = 1'b1;
        ifu_araddr  = random_addr();
        while (!saw_full) begin
            @(posedge clk);
            if (!ifu_arready) begin
                saw_full = 1'b1;
            end else begin
                @(negedge clk);
                ifu_araddr = random_addr();
            end
        end
        @(negedge clk);
        ifu_rready = 1'b1;
        @(posedge clk);
        while (!ifu_arready) @(posedge clk);
        @(negedge clk);
        ifu_arvalid = 1'b0;
        wait_responses();
        // nothing left over once every request is answered
        checks++;
        assert (!ifu_rvalid) else begin
            $display("[ERROR] ifu_rvalid got %h expected 0", ifu_rvalid);
            errors++;
        end
        report_test("back-pressure", errors_before);

        $display("tests: %0d, checks: %0d, requests: %0d, responses: %0d, errors: %0d",
                 tests, checks, requests, responses, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
